// ==== cache_pkg.sv ====
package cache_pkg;

  // ----------------------------------------------------------------------
  // address fields
  // ----------------------------------------------------------------------
  // cache index, virtual bits 9..2
  localparam int idx_w     = 8;
  localparam int idx_lsb   = 2;
  // tlb index, virtual bits 17..10
  localparam int tlb_idx_w = 8;
  localparam int tlb_lsb   = 10;
  // virtual page tag, bits 31..18
  localparam int vtag_w    = 14;
  localparam int vtag_lsb  = 18;
  // physical page and cache tag (physical bits 31..10)
  localparam int ppage_w   = 14;
  localparam int ctag_w    = 22;
  // memory word address, physical bits 31..2
  localparam int word_addr_w = 30;

  localparam int tlb_depth  = 256;
  localparam int line_depth = 256;

  // tlb write data layout
  localparam int tlbw_vtag_lsb  = 16;
  localparam int tlbw_ppage_lsb = 0;

  // ----------------------------------------------------------------------
  // enums
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_TLB_WRITE
  } cpu_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_COMPARE,
    S_REFILL_EVEN,
    S_REFILL_ODD,
    S_WRITE_MEM,
    S_RESPOND,
    S_WAIT_DROP
  } miss_state_e;

  // ----------------------------------------------------------------------
  // structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    cpu_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        fault;
  } cpu_rsp_t;

  typedef struct packed {
    logic                   we;
    logic [word_addr_w-1:0] addr;
    logic [31:0]            wdata;
  } mem_req_t;

  // translation result handed to the compare stage
  typedef struct packed {
    logic [ppage_w-1:0]   ppage;
    logic                 valid;
    logic                 match;
    logic [tlb_idx_w-1:0] tlb_idx;
  } lookup_t;

endpackage

// ==== cache_tlb.sv ====
module cache_tlb import cache_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        lookup,
  input  logic [31:0] vaddr,
  input  logic        tlb_we,
  input  logic [31:0] tlb_wdata,
  output lookup_t     tlb_out
);

  // entry storage, only the valid bits are cleared
  logic [tlb_depth-1:0] tlb_valid;
  logic [vtag_w-1:0]    tlb_vtag  [tlb_depth];
  logic [ppage_w-1:0]   tlb_ppage [tlb_depth];

  logic [tlb_idx_w-1:0] idx;

  // read stage
  logic                 rd_valid;
  logic [vtag_w-1:0]    rd_vtag;
  logic [ppage_w-1:0]   rd_ppage;
  logic [vtag_w-1:0]    req_vtag;
  logic [tlb_idx_w-1:0] rd_idx;

  // same index field for lookup and for install
  assign idx = vaddr[tlb_lsb +: tlb_idx_w];

  // ----------------------------------------------------------------------
  // valid bits and registered valid
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      tlb_valid <= '0;
      rd_valid  <= 1'b0;
    end
    else
    begin
      if (tlb_we)
        tlb_valid[idx] <= 1'b1;
      if (lookup)
        rd_valid <= tlb_valid[idx];
    end
  end

  // ----------------------------------------------------------------------
  // tag and page arrays
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_we)
    begin
      tlb_vtag[idx]  <= tlb_wdata[tlbw_vtag_lsb +: vtag_w];
      tlb_ppage[idx] <= tlb_wdata[tlbw_ppage_lsb +: ppage_w];
    end
    if (lookup)
    begin
      rd_vtag  <= tlb_vtag[idx];
      rd_ppage <= tlb_ppage[idx];
      req_vtag <= vaddr[vtag_lsb +: vtag_w];
      rd_idx   <= idx;
    end
  end

  // match needs a valid entry with the same virtual tag
  assign tlb_out = '{ppage:   rd_ppage,
                     valid:   rd_valid,
                     match:   rd_valid && (rd_vtag == req_vtag),
                     tlb_idx: rd_idx};

  // controller never looks up and installs in the same cycle
  a_no_lookup_during_write: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    !(lookup && tlb_we)
  );

endmodule

// ==== cache_tag_data.sv ====
module cache_tag_data import cache_pkg::*;
(
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               lookup,
  input  logic [31:0]        vaddr,
  input  lookup_t            tlb_out,
  input  logic               arr_we,
  input  logic [idx_w-1:0]   arr_idx,
  input  logic [ctag_w-1:0]  arr_tag,
  input  logic [31:0]        arr_wdata,
  output logic               hit,
  output logic [31:0]        hit_data,
  output logic [ppage_w-1:0] ppage,
  output logic               tlb_ok
);

  logic [line_depth-1:0] line_valid;
  logic [ctag_w-1:0]     line_tag  [line_depth];
  logic [31:0]           line_data [line_depth];

  logic [idx_w-1:0]  idx;
  logic              lk_d;
  logic              rd_valid;
  logic [ctag_w-1:0] rd_tag;
  logic [31:0]       rd_data;
  logic [ctag_w-1:0] phys_tag;

  // index sits in the page offset, so no translation needed
  assign idx = vaddr[idx_lsb +: idx_w];

  // physical page joined with the untranslated bits 17..10
  assign phys_tag = {tlb_out.ppage, tlb_out.tlb_idx};

  // ----------------------------------------------------------------------
  // array stage, read alongside the tlb
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      line_valid <= '0;
      rd_valid   <= 1'b0;
      lk_d       <= 1'b0;
    end
    else
    begin
      lk_d <= lookup;
      if (arr_we)
        line_valid[arr_idx] <= 1'b1;
      if (lookup)
        rd_valid <= line_valid[idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (arr_we)
    begin
      line_tag[arr_idx]  <= arr_tag;
      line_data[arr_idx] <= arr_wdata;
    end
    if (lookup)
    begin
      rd_tag  <= line_tag[idx];
      rd_data <= line_data[idx];
    end
  end

  // ----------------------------------------------------------------------
  // compare stage
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      hit    <= 1'b0;
      tlb_ok <= 1'b0;
    end
    else if (lk_d)
    begin
      hit    <= rd_valid && tlb_out.match && (rd_tag == phys_tag);
      tlb_ok <= tlb_out.valid && tlb_out.match;
    end
  end

  // results hold until the next lookup
  always_ff @(posedge CPU_CLK)
  begin
    if (lk_d)
    begin
      hit_data <= rd_data;
      ppage    <= tlb_out.ppage;
    end
  end

  // a cache hit is only possible through a good translation
  a_hit_needs_tlb: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    hit |-> tlb_ok
  );

endmodule

// ==== cache_miss_ctrl.sv ====
module cache_miss_ctrl import cache_pkg::*;
(
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               cpu_req_valid,
  input  cpu_req_t           cpu_req,
  input  logic               hit,
  input  logic [31:0]        hit_data,
  input  logic [ppage_w-1:0] ppage,
  input  logic               tlb_ok,
  input  logic               mem_ack,
  input  logic [31:0]        mem_rdata,
  output logic               cpu_ack,
  output cpu_rsp_t           cpu_rsp,
  output logic               lookup,
  output logic [31:0]        vaddr,
  output logic               tlb_we,
  output logic [31:0]        tlb_wdata,
  output logic               arr_we,
  output logic [idx_w-1:0]   arr_idx,
  output logic [ctag_w-1:0]  arr_tag,
  output logic [31:0]        arr_wdata,
  output logic               mem_req_valid,
  output mem_req_t           mem_req
);

  miss_state_e state;
  cpu_req_t    req_r;
  // strobe delayed to the compare result
  logic [1:0]  lk_pipe;
  logic        decide;
  logic        mem_done;
  logic        mem_idle;
  logic        refill_wr;
  logic        write_hit_wr;

  assign lookup    = (state == S_LOOKUP) && (req_r.op != OP_TLB_WRITE);
  assign tlb_we    = (state == S_LOOKUP) && (req_r.op == OP_TLB_WRITE);
  assign vaddr     = req_r.addr;
  assign tlb_wdata = req_r.wdata;

  assign decide   = (state == S_COMPARE) && lk_pipe[1];
  assign mem_done = mem_req_valid && mem_ack;
  assign mem_idle = !mem_req_valid && !mem_ack;

  // ----------------------------------------------------------------------
  // array write port
  // ----------------------------------------------------------------------
  assign refill_wr    = ((state == S_REFILL_EVEN) || (state == S_REFILL_ODD)) && mem_done;
  assign write_hit_wr = decide && tlb_ok && (req_r.op == OP_WRITE) && hit;

  assign arr_we    = refill_wr || write_hit_wr;
  assign arr_idx   = refill_wr ? {req_r.addr[idx_lsb+1 +: idx_w-1], mem_req.addr[0]}
                               : req_r.addr[idx_lsb +: idx_w];
  assign arr_tag   = {ppage, req_r.addr[tlb_lsb +: tlb_idx_w]};
  assign arr_wdata = refill_wr ? mem_rdata : req_r.wdata;

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state         <= S_IDLE;
      lk_pipe       <= 2'b00;
      cpu_ack       <= 1'b0;
      mem_req_valid <= 1'b0;
    end
    else
    begin
      lk_pipe <= {lk_pipe[0], lookup};
      case (state)
        S_IDLE:
          if (cpu_req_valid)
            state <= S_LOOKUP;
        S_LOOKUP:
          state <= (req_r.op == OP_TLB_WRITE) ? S_RESPOND : S_COMPARE;
        S_COMPARE:
          if (decide)
          begin
            if (!tlb_ok)
            begin
              cpu_ack <= 1'b1;
              state   <= S_WAIT_DROP;
            end
            else if (req_r.op == OP_WRITE)
            begin
              mem_req_valid <= 1'b1;
              state         <= S_WRITE_MEM;
            end
            else if (hit)
            begin
              cpu_ack <= 1'b1;
              state   <= S_WAIT_DROP;
            end
            else
            begin
              mem_req_valid <= 1'b1;
              state         <= S_REFILL_EVEN;
            end
          end
        S_REFILL_EVEN:
          if (mem_done)
            mem_req_valid <= 1'b0;
          else if (mem_idle)
          begin
            // even word finished, start the odd one
            mem_req_valid <= 1'b1;
            state         <= S_REFILL_ODD;
          end
        S_REFILL_ODD, S_WRITE_MEM:
          if (mem_done)
            mem_req_valid <= 1'b0;
          else if (mem_idle)
            state <= S_RESPOND;
        S_RESPOND:
        begin
          cpu_ack <= 1'b1;
          state   <= S_WAIT_DROP;
        end
        S_WAIT_DROP:
          if (!cpu_req_valid)
          begin
            cpu_ack <= 1'b0;
            state   <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // request, response and memory request payload
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if ((state == S_IDLE) && cpu_req_valid)
      req_r <= cpu_req;
    if (tlb_we)
      cpu_rsp <= '{rdata: '0, fault: 1'b0};
    if (decide)
    begin
      if (!tlb_ok)
        cpu_rsp <= '{rdata: '0, fault: 1'b1};
      else if (req_r.op == OP_WRITE)
      begin
        cpu_rsp <= '{rdata: '0, fault: 1'b0};
        mem_req <= '{we: 1'b1, addr: {ppage, req_r.addr[17:2]}, wdata: req_r.wdata};
      end
      else if (hit)
        cpu_rsp <= '{rdata: hit_data, fault: 1'b0};
      else
        mem_req <= '{we: 1'b0, addr: {ppage, req_r.addr[17:3], 1'b0}, wdata: '0};
    end
    if ((state == S_REFILL_EVEN) && mem_idle)
      mem_req.addr[0] <= 1'b1;
    // keep the word the CPU asked for
    if (refill_wr && (mem_req.addr[0] == req_r.addr[2]))
      cpu_rsp <= '{rdata: mem_rdata, fault: 1'b0};
  end

  a_mem_req_stable: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    (mem_req_valid && !mem_ack) |=> $stable(mem_req)
  );

  a_ack_needs_req: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) |-> $past(cpu_req_valid)
  );

endmodule

// ==== cache_top.sv ====
module cache_top import cache_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        cpu_req_valid,
  input  cpu_req_t    cpu_req,
  output logic        cpu_ack,
  output cpu_rsp_t    cpu_rsp,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  input  logic        mem_ack,
  input  logic [31:0] mem_rdata
);

  // lookup strobe and request address
  logic               lookup;
  logic [31:0]        vaddr;
  // tlb install
  logic               tlb_we;
  logic [31:0]        tlb_wdata;
  lookup_t            tlb_out;
  // compare results
  logic               hit;
  logic [31:0]        hit_data;
  logic [ppage_w-1:0] ppage;
  logic               tlb_ok;
  // array write port
  logic               arr_we;
  logic [idx_w-1:0]   arr_idx;
  logic [ctag_w-1:0]  arr_tag;
  logic [31:0]        arr_wdata;

  cache_tlb cache_tlb_inst (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .lookup    (lookup),
    .vaddr     (vaddr),
    .tlb_we    (tlb_we),
    .tlb_wdata (tlb_wdata),
    .tlb_out   (tlb_out)
  );

  cache_tag_data cache_tag_data_inst (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .lookup    (lookup),
    .vaddr     (vaddr),
    .tlb_out   (tlb_out),
    .arr_we    (arr_we),
    .arr_idx   (arr_idx),
    .arr_tag   (arr_tag),
    .arr_wdata (arr_wdata),
    .hit       (hit),
    .hit_data  (hit_data),
    .ppage     (ppage),
    .tlb_ok    (tlb_ok)
  );

  cache_miss_ctrl cache_miss_ctrl_inst (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .hit           (hit),
    .hit_data      (hit_data),
    .ppage         (ppage),
    .tlb_ok        (tlb_ok),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .cpu_ack       (cpu_ack),
    .cpu_rsp       (cpu_rsp),
    .lookup        (lookup),
    .vaddr         (vaddr),
    .tlb_we        (tlb_we),
    .tlb_wdata     (tlb_wdata),
    .arr_we        (arr_we),
    .arr_idx       (arr_idx),
    .arr_tag       (arr_tag),
    .arr_wdata     (arr_wdata),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req)
  );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen
(
  output logic CPU_CLK,
  output logic RST
);

  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial
  begin
    CPU_CLK = 1'b0;
    forever #50 CPU_CLK = ~CPU_CLK;
  end

  // active low reset held for 10 cycles, released just after an edge
  initial
  begin
    RST = 1'b0;
    repeat (10) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;
  end

endmodule

// ==== tb_cache.sv ====
module tb_cache
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_random_ops = 400;
  localparam int cycles_per_op  = 40;
  localparam int max_cycles     = num_random_ops * cycles_per_op;
  localparam int mem_words      = 1024;

  logic        CPU_CLK;
  logic        RST;
  logic        cpu_req_valid;
  cpu_req_t    cpu_req;
  logic        cpu_ack;
  cpu_rsp_t    cpu_rsp;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  // memory model storage, word index is physical bits 11..2
  logic [31:0] mem [mem_words];
  int unsigned mem_delay_max;
  mem_req_t    mem_log_q [$];

  // reference state: memory, tlb and a shadow of the cache arrays
  logic [31:0]        ref_mem        [mem_words];
  logic               ref_tlb_valid  [tlb_depth];
  logic [vtag_w-1:0]  ref_tlb_vtag   [tlb_depth];
  logic [ppage_w-1:0] ref_tlb_ppage  [tlb_depth];
  logic               ref_line_valid [line_depth];
  logic [ctag_w-1:0]  ref_line_tag   [line_depth];
  logic [31:0]        ref_line_data  [line_depth];
  mem_req_t           exp_xfer_q [$];

  // handoff between driver and checker
  event     op_done;
  cpu_op_e  cur_op;
  cpu_rsp_t exp_rsp;
  cpu_rsp_t got_rsp;
  int       exp_xfers;
  int       got_lat;
  int       seen_xfers;
  int       cycles;

  tb_clock_gen clock_gen_inst (
    .CPU_CLK (CPU_CLK),
    .RST     (RST)
  );

  cache_top cache_top_inst (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_ack       (cpu_ack),
    .cpu_rsp       (cpu_rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] make_vaddr(input logic [vtag_w-1:0] vtag,
                                             input logic [7:0] tidx,
                                             input logic [7:0] cidx);
    return {vtag, tidx, cidx, 2'b00};
  endfunction

  // virtual tag in 29..16, physical page in 13..0
  function automatic logic [31:0] make_tlb_data(input logic [vtag_w-1:0] vtag,
                                                input logic [ppage_w-1:0] page);
    return {2'b00, vtag, 2'b00, page};
  endfunction

  function automatic cpu_req_t make_req(input cpu_op_e op, input logic [31:0] addr,
                                        input logic [31:0] wdata);
    return '{op: op, addr: addr, wdata: wdata};
  endfunction

  task automatic stop_on_error();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
    stop_on_error();
  endtask

  // ----------------------------------------------------------------------
  // reference model, also queues the memory transfers it expects
  // ----------------------------------------------------------------------
  function automatic void predict_op(input cpu_req_t r, output cpu_rsp_t rsp,
                                     output int n_xfer);
    logic [7:0]  ti;
    logic [7:0]  ci;
    logic [7:0]  li;
    logic [31:0] pa;
    logic [29:0] wa;
    logic [29:0] lw;
    logic [21:0] ct;
    logic        hit;
    ti  = r.addr[17:10];
    ci  = r.addr[9:2];
    rsp = '0;
    exp_xfer_q.delete();
    if (r.op == OP_TLB_WRITE)
    begin
      ref_tlb_valid[ti] = 1'b1;
      ref_tlb_vtag[ti]  = r.wdata[29:16];
      ref_tlb_ppage[ti] = r.wdata[13:0];
    end
    else if (!ref_tlb_valid[ti] || (ref_tlb_vtag[ti] != r.addr[31:18]))
      rsp.fault = 1'b1;
    else
    begin
      pa  = {ref_tlb_ppage[ti], r.addr[17:0]};
      wa  = pa[31:2];
      ct  = pa[31:10];
      hit = ref_line_valid[ci] && (ref_line_tag[ci] == ct);
      if (r.op == OP_WRITE)
      begin
        exp_xfer_q.push_back('{we: 1'b1, addr: wa, wdata: r.wdata});
        ref_mem[wa[9:0]] = r.wdata;
        if (hit)
          ref_line_data[ci] = r.wdata;
      end
      else if (hit)
        rsp.rdata = ref_line_data[ci];
      else
      begin
        // even word first, then odd
        for (int w = 0; w < 2; w++)
        begin
          lw = {wa[29:1], w[0]};
          li = {ci[7:1], w[0]};
          exp_xfer_q.push_back('{we: 1'b0, addr: lw, wdata: '0});
          ref_line_valid[li] = 1'b1;
          ref_line_tag[li]   = ct;
          ref_line_data[li]  = ref_mem[lw[9:0]];
        end
        rsp.rdata = ref_mem[wa[9:0]];
      end
    end
    n_xfer = exp_xfer_q.size();
  endfunction

  // ----------------------------------------------------------------------
  // cpu side driver
  // ----------------------------------------------------------------------
  task automatic run_op(input cpu_req_t r);
    int waited;
    int drop_wait;
    predict_op(r, exp_rsp, exp_xfers);
    cur_op = r.op;
    @(posedge CPU_CLK);
    #1;
    cpu_req       = r;
    cpu_req_valid = 1'b1;
    waited        = 0;
    do
    begin
      @(posedge CPU_CLK);
      #1;
      waited++;
    end
    while (!cpu_ack);
    got_rsp = cpu_rsp;
    // first edge only samples req
    got_lat = waited - 1;
    -> op_done;
    cpu_req_valid = 1'b0;
    drop_wait     = 0;
    do
    begin
      @(posedge CPU_CLK);
      #1;
      drop_wait++;
    end
    while (cpu_ack);
    assert (drop_wait == 1)
    else
      report_mismatch("cpu_ack fall delay", 32'd1, 32'(drop_wait));
  endtask

  task automatic expect_xfers(input int n);
    assert (seen_xfers == n)
    else
      report_mismatch("memory transfer count", 32'(n), 32'(seen_xfers));
  endtask

  // ----------------------------------------------------------------------
  // memory model, four-phase handshake with random delay
  // ----------------------------------------------------------------------
  initial
  begin
    int unsigned delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge CPU_CLK);
      if (RST && mem_req_valid)
      begin
        delay = $urandom_range(0, mem_delay_max);
        repeat (delay) @(posedge CPU_CLK);
        #1;
        mem_log_q.push_back(mem_req);
        if (mem_req.we)
          mem[mem_req.addr[9:0]] = mem_req.wdata;
        else
          mem_rdata = mem[mem_req.addr[9:0]];
        mem_ack = 1'b1;
        do
        begin
          @(posedge CPU_CLK);
        end
        while (mem_req_valid);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // checker
  // ----------------------------------------------------------------------
  initial
  begin
    int exp_lat;
    forever
    begin
      @(op_done);
      assert (got_rsp.fault == exp_rsp.fault)
      else
        report_mismatch("cpu_rsp.fault", 32'(exp_rsp.fault), 32'(got_rsp.fault));
      assert (got_rsp.rdata == exp_rsp.rdata)
      else
        report_mismatch("cpu_rsp.rdata", exp_rsp.rdata, got_rsp.rdata);
      assert (mem_log_q.size() == exp_xfers)
      else
        report_mismatch("memory transfer count", 32'(exp_xfers), 32'(mem_log_q.size()));
      foreach (exp_xfer_q[i])
      begin
        assert (mem_log_q[i].we == exp_xfer_q[i].we)
        else
          report_mismatch("mem_req.we", 32'(exp_xfer_q[i].we), 32'(mem_log_q[i].we));
        assert (mem_log_q[i].addr == exp_xfer_q[i].addr)
        else
          report_mismatch("mem_req.addr", 32'(exp_xfer_q[i].addr), 32'(mem_log_q[i].addr));
        if (exp_xfer_q[i].we)
        begin
          assert (mem_log_q[i].wdata == exp_xfer_q[i].wdata)
          else
            report_mismatch("mem_req.wdata", exp_xfer_q[i].wdata, mem_log_q[i].wdata);
        end
      end
      seen_xfers = mem_log_q.size();
      mem_log_q.delete();
      // fixed ack timing when memory is not involved
      if (exp_xfers == 0)
      begin
        exp_lat = (cur_op == OP_TLB_WRITE) ? 2 : 3;
        assert (got_lat == exp_lat)
        else
          report_mismatch("cpu_ack latency", 32'(exp_lat), 32'(got_lat));
      end
    end
  end

  // timeout
  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge CPU_CLK);
      cycles++;
      if (cycles >= max_cycles)
      begin
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        stop_on_error();
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial
  begin
    logic [31:0]       va_a;
    logic [31:0]       va_b;
    logic [31:0]       va_c;
    logic [31:0]       addr;
    logic [vtag_w-1:0] vtag;
    logic [7:0]        tidx;
    logic [7:0]        cidx;
    int unsigned       sel;
    void'($urandom(55));
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    mem_delay_max = 2;
    for (int i = 0; i < mem_words; i++)
    begin
      mem[i]     = $urandom;
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < tlb_depth; i++)
      ref_tlb_valid[i] = 1'b0;
    for (int i = 0; i < line_depth; i++)
      ref_line_valid[i] = 1'b0;
    wait (RST === 1'b1);

    va_a = make_vaddr(14'h00a5, 8'h05, 8'h10);
    va_b = make_vaddr(14'h00b6, 8'h06, 8'h10);
    va_c = make_vaddr(14'h00a5, 8'h05, 8'h40);

    // no translation yet, both fault
    run_op(make_req(OP_READ, va_a, '0));
    expect_xfers(0);
    run_op(make_req(OP_WRITE, va_a, 32'h1234_5678));
    expect_xfers(0);

    // install and refill
    run_op(make_req(OP_TLB_WRITE, va_a, make_tlb_data(14'h00a5, 14'h0123)));
    run_op(make_req(OP_READ, va_a, '0));
    expect_xfers(2);
    run_op(make_req(OP_READ, va_a, '0));
    expect_xfers(0);
    run_op(make_req(OP_READ, va_a ^ 32'h4, '0));
    expect_xfers(0);

    // write-through, line present then absent
    run_op(make_req(OP_WRITE, va_a, 32'hcafe_0001));
    expect_xfers(1);
    run_op(make_req(OP_READ, va_a, '0));
    expect_xfers(0);
    run_op(make_req(OP_WRITE, va_c, 32'hbeef_0002));
    expect_xfers(1);
    run_op(make_req(OP_READ, va_c, '0));
    expect_xfers(2);

    // same index, different physical tag
    run_op(make_req(OP_TLB_WRITE, va_b, make_tlb_data(14'h00b6, 14'h0234)));
    run_op(make_req(OP_READ, va_b, '0));
    expect_xfers(2);
    run_op(make_req(OP_READ, va_a, '0));
    expect_xfers(2);
    run_op(make_req(OP_READ, va_b, '0));
    expect_xfers(2);

    // random mix over a small address space so hits and conflicts happen
    for (int n = 0; n < num_random_ops; n++)
    begin
      if (n % 50 == 0)
        mem_delay_max = $urandom_range(0, 3);
      sel  = $urandom_range(0, 19);
      vtag = 14'($urandom_range(0, 1));
      tidx = 8'($urandom_range(0, 3));
      cidx = 8'($urandom_range(0, 7));
      addr = make_vaddr(vtag, tidx, cidx);
      if (sel < 3)
        run_op(make_req(OP_TLB_WRITE, addr,
                        make_tlb_data(vtag, 14'($urandom_range(0, 3)))));
      else if (sel < 9)
        run_op(make_req(OP_WRITE, addr, $urandom));
      else
        run_op(make_req(OP_READ, addr, '0));
    end

    repeat (2) @(posedge CPU_CLK);
    if (mem_log_q.size() == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("memory request seen with no operation outstanding");
      stop_on_error();
    end
  end

endmodule

// ==== sources.f ====
cache_pkg.sv
cache_tlb.sv
cache_tag_data.sv
cache_miss_ctrl.sv
cache_top.sv
tb_clock_gen.sv
tb_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cache -f sources.f -o sim_cache

./obj_dir/sim_cache | tee sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
